//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module bp_tb -o bp_sim

./obj_dir/bp_sim 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi

exit 0

//--- src.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/pht_index_hash.sv
verilog/pht_bank.sv
verilog/pred_collect.sv
verilog/ghr.sv
verilog/bp_top.sv
tb/bp_tb.sv

//--- tb/bp_tb.sv
`default_nettype none

`include "bp_cfg.svh"

module bp_tb
    import bp_pkg::*;
();

    localparam int NUM_DIRECTED = 23 + `BP_QUEUE_LEN;
    localparam int NUM_RANDOM   = 300;
    localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
    localparam int RSP_TIMEOUT  = 20;
    localparam int NUM_IDX      = 1 << `BP_GH_WIDTH;

    typedef enum logic [1:0] {
        op_pred,
        op_hit,    // resolve oldest with the predicted outcome
        op_miss,   // resolve oldest with the opposite outcome
        op_rand
    } op_e;

    typedef struct packed {
        op_e                     op;
        logic [`BP_PC_WIDTH-1:0] pc;
        logic [1:0]              exp_taken;   // 2 means no value in the table
        logic                    chk_gh;
        logic [`BP_GH_WIDTH-1:0] exp_gh;
    } step_t;

    typedef struct packed {
        logic [`BP_GH_WIDTH-1:0] index;
        logic                    taken;
        logic [`BP_GH_WIDTH-1:0] gh_alt;   // history if this branch went the other way
    } pend_t;

    logic                    clk;
    logic                    rstn;
    logic                    pred_req_valid;
    pred_req_t               pred_req;
    logic                    resolve_valid;
    resolve_t                resolve;
    logic                    pred_rsp_valid;
    pred_rsp_t               pred_rsp;
    logic [`BP_GH_WIDTH-1:0] gh;

    step_t                   steps [NUM_OPS];
    logic [1:0]              m_ctr [NUM_IDX];
    logic [`BP_GH_WIDTH-1:0] m_gh;
    pend_t                   pend_q [$];
    int                      max_depth;
    integer                  seed;

    bp_top DUT (
        .clk            (clk),
        .rstn           (rstn),
        .pred_req_valid (pred_req_valid),
        .pred_req       (pred_req),
        .resolve_valid  (resolve_valid),
        .resolve        (resolve),
        .pred_rsp_valid (pred_rsp_valid),
        .pred_rsp       (pred_rsp),
        .gh             (gh)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic stop_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
            stop_run();
        end
    endtask

    // 2-bit saturating counter step
    function automatic logic [1:0] next_count(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    task automatic set_step(input int i, input op_e op, input logic [31:0] pc,
                            input logic [1:0] exp_taken, input logic chk_gh,
                            input logic [`BP_GH_WIDTH-1:0] exp_gh);
        steps[i] = '{op, pc, exp_taken, chk_gh, exp_gh};
    endtask

    task automatic fill_table();
        // index 0x10 walked weak_nt -> weak_t -> strong_t and back
        set_step(0,  op_pred, 32'h040, 2'd0, 1'b1, 8'h00);
        set_step(1,  op_miss, 32'h000, 2'd2, 1'b1, 8'h01);
        set_step(2,  op_pred, 32'h044, 2'd1, 1'b1, 8'h03);
        set_step(3,  op_hit,  32'h000, 2'd2, 1'b1, 8'h03);
        set_step(4,  op_pred, 32'h04c, 2'd1, 1'b1, 8'h07);
        set_step(5,  op_miss, 32'h000, 2'd2, 1'b1, 8'h06);
        set_step(6,  op_pred, 32'h058, 2'd1, 1'b1, 8'h0d);
        set_step(7,  op_hit,  32'h000, 2'd2, 1'b1, 8'h0d);
        set_step(8,  op_pred, 32'h074, 2'd1, 1'b1, 8'h1b);
        set_step(9,  op_hit,  32'h000, 2'd2, 1'b1, 8'h1b);   // stays strong_t
        set_step(10, op_pred, 32'h02c, 2'd1, 1'b1, 8'h37);
        set_step(11, op_hit,  32'h000, 2'd2, 1'b1, 8'h37);
        set_step(12, op_pred, 32'h09c, 2'd1, 1'b1, 8'h6f);
        set_step(13, op_miss, 32'h000, 2'd2, 1'b1, 8'h6e);
        set_step(14, op_pred, 32'h1f8, 2'd1, 1'b1, 8'hdd);   // weak_t after one miss
        set_step(15, op_hit,  32'h000, 2'd2, 1'b1, 8'hdd);
        // several in flight and a recovery from the second one
        set_step(16, op_pred, 32'h1000, 2'd2, 1'b0, 8'h00);
        set_step(17, op_pred, 32'h2344, 2'd2, 1'b0, 8'h00);
        set_step(18, op_pred, 32'h0abc, 2'd2, 1'b0, 8'h00);
        set_step(19, op_pred, 32'h7770, 2'd2, 1'b0, 8'h00);
        set_step(20, op_hit,  32'h000, 2'd2, 1'b0, 8'h00);
        set_step(21, op_miss, 32'h000, 2'd2, 1'b0, 8'h00);
        // full checkpoint queue, recovery from the deepest entry
        for (int i = 0; i < `BP_QUEUE_LEN; i++) begin
            set_step(22 + i, op_pred, 32'h3000 + 32'(i) * 32'h2c, 2'd2, 1'b0, 8'h00);
        end
        set_step(22 + `BP_QUEUE_LEN, op_miss, 32'h000, 2'd2, 1'b0, 8'h00);
        for (int i = NUM_DIRECTED; i < NUM_OPS; i++) begin
            set_step(i, op_rand, 32'h0, 2'd2, 1'b0, 8'h00);
        end
    endtask

    task automatic predict_branch(input int n, input logic [`BP_PC_WIDTH-1:0] pc,
                                  input logic [1:0] exp_taken);
        logic [`BP_GH_WIDTH-1:0] exp_idx;
        logic                    exp_pred;
        pend_t                   ent;
        int                      waited;
        exp_idx  = pc[`BP_GH_WIDTH+1:2] ^ m_gh;   // word bits xor history
        exp_pred = m_ctr[exp_idx][1];
        pred_req_valid = 1'b1;
        pred_req.pc    = pc;
        waited = 0;
        @(posedge clk);
        #1;
        pred_req_valid = 1'b0;
        while (!pred_rsp_valid) begin
            waited++;
            if (waited > RSP_TIMEOUT) begin
                $display("timeout: no prediction response for step %0d", n);
                stop_run();
            end
            @(posedge clk);
            #1;
        end
        check_val($sformatf("step %0d latency", n), 32'd0, 32'(waited));
        check_val($sformatf("step %0d taken", n), 32'(exp_pred), 32'(pred_rsp.taken));
        check_val($sformatf("step %0d index", n), 32'(exp_idx), 32'(pred_rsp.index));
        check_val($sformatf("step %0d rsp gh", n), 32'(m_gh), 32'(pred_rsp.gh));
        check_val($sformatf("step %0d gh in rsp cycle", n), 32'(m_gh), 32'(gh));
        if (exp_taken != 2'd2) begin
            check_val($sformatf("step %0d table taken", n), 32'(exp_taken),
                      32'(pred_rsp.taken));
        end
        ent.index  = exp_idx;
        ent.taken  = exp_pred;
        ent.gh_alt = {m_gh[`BP_GH_WIDTH-2:0], ~exp_pred};
        pend_q.push_back(ent);
        if (pend_q.size() > max_depth) begin
            max_depth = pend_q.size();
        end
        m_gh = {m_gh[`BP_GH_WIDTH-2:0], exp_pred};
        @(posedge clk);
        #1;
        check_val($sformatf("step %0d rsp pulse", n), 32'd0, 32'(pred_rsp_valid));
        check_val($sformatf("step %0d gh shift", n), 32'(m_gh), 32'(gh));
    endtask

    task automatic resolve_oldest(input int n, input logic hit);
        pend_t ent;
        logic  actual;
        if (pend_q.size() == 0) begin
            $display("step %0d resolves with no branch outstanding", n);
            stop_run();
        end
        ent    = pend_q.pop_front();   // oldest
        actual = hit ? ent.taken : ~ent.taken;
        resolve_valid       = 1'b1;
        resolve.index       = ent.index;
        resolve.pred_taken  = ent.taken;
        resolve.taken       = actual;
        @(posedge clk);
        #1;
        resolve_valid = 1'b0;
        m_ctr[ent.index] = next_count(m_ctr[ent.index], actual);
        if (!hit) begin
            m_gh = ent.gh_alt;
            pend_q.delete();   // younger branches flushed
        end
        check_val($sformatf("step %0d gh after resolve", n), 32'(m_gh), 32'(gh));
    endtask

    task automatic random_op(input int n);
        logic [31:0] r;
        logic [31:0] pc_r;
        r    = $random(seed);
        pc_r = $random(seed);
        if (pend_q.size() == 0 ||
            (pend_q.size() < `BP_QUEUE_LEN && r[1:0] != 2'b00)) begin
            predict_branch(n, pc_r, 2'd2);
        end else begin
            resolve_oldest(n, r[4:2] != 3'b000);   // mostly correct with a few recoveries
        end
    endtask

    initial begin
        seed           = 32'h074d52fb;
        max_depth      = 0;
        rstn           = 1'b0;
        pred_req_valid = 1'b0;
        pred_req       = '0;
        resolve_valid  = 1'b0;
        resolve        = '0;
        m_gh           = '0;
        for (int i = 0; i < NUM_IDX; i++) begin
            m_ctr[i] = 2'b01;   // weak_nt
        end
        fill_table();
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_val("reset gh", 32'd0, 32'(gh));
        check_val("reset rsp_valid", 32'd0, 32'(pred_rsp_valid));
        for (int i = 0; i < NUM_OPS; i++) begin
            case (steps[i].op)
                op_pred: predict_branch(i, steps[i].pc, steps[i].exp_taken);
                op_hit:  resolve_oldest(i, 1'b1);
                op_miss: resolve_oldest(i, 1'b0);
                default: random_op(i);
            endcase
            if (steps[i].chk_gh) begin
                check_val($sformatf("step %0d table gh", i), 32'(steps[i].exp_gh), 32'(gh));
            end
        end
        check_val("max outstanding branches", `BP_QUEUE_LEN, 32'(max_depth));
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// global history length, also the PHT index width
`define BP_GH_WIDTH     8

`define BP_PC_WIDTH     32

// banks are picked by the low index bits
`define BP_NUM_BANKS    4

// 2**BP_GH_WIDTH / BP_NUM_BANKS
`define BP_BANK_ROWS    64

// checkpoint depth = max unresolved branches
`define BP_QUEUE_LEN    16

`define BP_BANK_BITS    $clog2(`BP_NUM_BANKS)
`define BP_ROW_BITS     $clog2(`BP_BANK_ROWS)
`define BP_CNT_BITS     $clog2(`BP_QUEUE_LEN + 1)

`endif

//--- verilog/bp_pkg.sv
`default_nettype none

`include "bp_cfg.svh"

package bp_pkg;

    // 2-bit saturating counter, msb is the direction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_state_e;

    typedef struct packed {
        logic [`BP_PC_WIDTH-1:0] pc;
    } pred_req_t;

    typedef struct packed {
        logic                    taken;
        logic [`BP_GH_WIDTH-1:0] index;   // returned by execute on resolve
        logic [`BP_GH_WIDTH-1:0] gh;      // history used for the index
    } pred_rsp_t;

    typedef struct packed {
        logic [`BP_GH_WIDTH-1:0] index;
        logic                    pred_taken;
        logic                    taken;   // actual outcome
    } resolve_t;

    typedef struct packed {
        logic [`BP_ROW_BITS-1:0] row;
        logic                    taken;   // train direction, write side only
    } bank_addr_t;

endpackage

`default_nettype wire

//--- verilog/bp_top.sv
`default_nettype none

`include "bp_cfg.svh"

module bp_top
    import bp_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    pred_req_valid,
    input  wire pred_req_t               pred_req,
    input  wire logic                    resolve_valid,
    input  wire resolve_t                resolve,
    output logic                         pred_rsp_valid,
    output pred_rsp_t                    pred_rsp,
    output logic [`BP_GH_WIDTH-1:0]      gh
);

    logic [`BP_NUM_BANKS-1:0] rd_sel;
    logic [`BP_NUM_BANKS-1:0] wr_sel;
    bank_addr_t               rd_addr;
    bank_addr_t               wr_addr;
    logic [`BP_GH_WIDTH-1:0]  index;
    logic [`BP_BANK_BITS-1:0] bank;
    ctr_state_e               rd_ctr [`BP_NUM_BANKS];

    pht_index_hash u_hash (
        .req_valid (pred_req_valid),
        .req       (pred_req),
        .gh        (gh),
        .res_valid (resolve_valid),
        .res       (resolve),
        .rd_sel    (rd_sel),
        .wr_sel    (wr_sel),
        .rd_addr   (rd_addr),
        .wr_addr   (wr_addr),
        .index     (index),
        .bank      (bank)
    );

    // row/dir buses are shared, strobes pick the bank
    for (genvar g = 0; g < `BP_NUM_BANKS; g++) begin : g_bank
        pht_bank u_bank (
            .clk     (clk),
            .rstn    (rstn),
            .rd_en   (rd_sel[g]),
            .rd_addr (rd_addr),
            .wr_en   (wr_sel[g]),
            .wr_addr (wr_addr),
            .rd_ctr  (rd_ctr[g])
        );
    end

    pred_collect u_collect (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (pred_req_valid),
        .bank      (bank),
        .index     (index),
        .gh_in     (gh),
        .rd_ctr    (rd_ctr),
        .rsp_valid (pred_rsp_valid),
        .rsp       (pred_rsp)
    );

    ghr u_ghr (
        .clk       (clk),
        .rstn      (rstn),
        .rsp_valid (pred_rsp_valid),
        .rsp_taken (pred_rsp.taken),
        .res_valid (resolve_valid),
        .res       (resolve),
        .gh        (gh)
    );

endmodule

`default_nettype wire

//--- verilog/ghr.sv
`default_nettype none

`include "bp_cfg.svh"

module ghr
    import bp_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    rsp_valid,
    input  wire logic                    rsp_taken,
    input  wire logic                    res_valid,
    input  wire resolve_t                res,
    output logic [`BP_GH_WIDTH-1:0]      gh
);

    // entry 0 is the youngest branch, entry cnt-1 the oldest
    logic [`BP_GH_WIDTH-1:0]          chkpt_q [`BP_QUEUE_LEN];
    logic [`BP_CNT_BITS-1:0]          cnt;
    logic [$clog2(`BP_QUEUE_LEN)-1:0] old_idx;
    logic                             mispred;
    logic [`BP_GH_WIDTH-1:0]          gh_spec;
    logic [`BP_GH_WIDTH-1:0]          gh_alt;
    logic [`BP_GH_WIDTH-1:0]          gh_restore;

    assign mispred = res_valid && (res.pred_taken != res.taken);

    assign gh_spec = {gh[`BP_GH_WIDTH-2:0], rsp_taken};
    assign gh_alt  = {gh[`BP_GH_WIDTH-2:0], ~rsp_taken};   // history if this one mispredicts

    // oldest in-flight branch
    assign old_idx    = cnt[$clog2(`BP_QUEUE_LEN)-1:0] - 1'b1;   // full queue wraps to last entry
    assign gh_restore = chkpt_q[old_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            gh <= '0;
        end else if (mispred) begin
            gh <= gh_restore;
        end else if (rsp_valid) begin
            gh <= gh_spec;
        end
    end

    // a checkpoint shifts in on every prediction
    always_ff @(posedge clk) begin
        if (rsp_valid && !mispred) begin
            chkpt_q[0] <= gh_alt;
            for (int i = `BP_QUEUE_LEN - 1; i > 0; i--) begin
                chkpt_q[i] <= chkpt_q[i-1];
            end
        end
    end

    // outstanding branch count
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (mispred) begin
            cnt <= '0;   // younger branches flushed
        end else if (res_valid && !rsp_valid) begin
            cnt <= cnt - 1'b1;
        end else if (rsp_valid && !res_valid) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pht_bank.sv
`default_nettype none

`include "bp_cfg.svh"

module pht_bank
    import bp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       rd_en,
    input  wire bank_addr_t rd_addr,
    input  wire logic       wr_en,
    input  wire bank_addr_t wr_addr,
    output ctr_state_e      rd_ctr
);

    ctr_state_e ctr [`BP_BANK_ROWS];

    // saturating step toward the resolved direction
    function automatic ctr_state_e train_ctr(input ctr_state_e cur, input logic taken);
        ctr_state_e nxt;
        nxt = cur;
        if (taken && cur != strong_t) begin
            nxt = ctr_state_e'(cur + 2'd1);
        end else if (!taken && cur != strong_nt) begin
            nxt = ctr_state_e'(cur - 2'd1);
        end
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < `BP_BANK_ROWS; r++) begin
                ctr[r] <= weak_nt;
            end
        end else if (wr_en) begin
            ctr[wr_addr.row] <= train_ctr(ctr[wr_addr.row], wr_addr.taken);
        end
    end

    // same-row train in this cycle is not seen here, read gets old value
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_ctr <= ctr[rd_addr.row];
        end
    end

endmodule

`default_nettype wire

//--- verilog/pht_index_hash.sv
`default_nettype none

`include "bp_cfg.svh"

module pht_index_hash
    import bp_pkg::*;
(
    input  wire logic                     req_valid,
    input  wire pred_req_t                req,
    input  wire logic [`BP_GH_WIDTH-1:0]  gh,
    input  wire logic                     res_valid,
    input  wire resolve_t                 res,
    output logic [`BP_NUM_BANKS-1:0]      rd_sel,
    output logic [`BP_NUM_BANKS-1:0]      wr_sel,
    output bank_addr_t                    rd_addr,
    output bank_addr_t                    wr_addr,
    output logic [`BP_GH_WIDTH-1:0]       index,
    output logic [`BP_BANK_BITS-1:0]      bank
);

    logic [`BP_BANK_BITS-1:0] wr_bank;

    // gshare: word-aligned pc bits xor history
    assign index   = req.pc[`BP_GH_WIDTH+1:2] ^ gh;
    assign bank    = index[`BP_BANK_BITS-1:0];
    assign wr_bank = res.index[`BP_BANK_BITS-1:0];

    always_comb begin
        rd_addr.row   = index[`BP_GH_WIDTH-1:`BP_BANK_BITS];
        rd_addr.taken = 1'b0;                                  // reads never train
        wr_addr.row   = res.index[`BP_GH_WIDTH-1:`BP_BANK_BITS];
        wr_addr.taken = res.taken;                             // train toward actual
    end

    // one-hot bank strobes
    always_comb begin
        rd_sel = '0;
        wr_sel = '0;
        if (req_valid) begin
            rd_sel[bank] = 1'b1;
        end
        if (res_valid) begin
            wr_sel[wr_bank] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pred_collect.sv
`default_nettype none

`include "bp_cfg.svh"

module pred_collect
    import bp_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     req_valid,
    input  wire logic [`BP_BANK_BITS-1:0] bank,
    input  wire logic [`BP_GH_WIDTH-1:0]  index,
    input  wire logic [`BP_GH_WIDTH-1:0]  gh_in,
    input  wire ctr_state_e               rd_ctr [`BP_NUM_BANKS],
    output logic                          rsp_valid,
    output pred_rsp_t                     rsp
);

    logic                     valid_q;
    logic [`BP_BANK_BITS-1:0] bank_q;
    logic [`BP_GH_WIDTH-1:0]  index_q;
    logic [`BP_GH_WIDTH-1:0]  gh_q;
    ctr_state_e               sel_ctr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    // request info lines up with the banks' registered read
    always_ff @(posedge clk) begin
        if (req_valid) begin
            bank_q  <= bank;
            index_q <= index;
            gh_q    <= gh_in;
        end
    end

    assign sel_ctr = rd_ctr[bank_q];

    assign rsp_valid = valid_q;

    always_comb begin
        rsp.taken = sel_ctr[1];   // msb of counter
        rsp.index = index_q;
        rsp.gh    = gh_q;
    end

endmodule

`default_nettype wire
